/* Makefile */
# Verilator build and run of the ALU testbench
VERILATOR ?= verilator
TOP ?= aluTb
FILELIST ?= src.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing -Wno-fatal
PASS_MSG ?= No errors

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* hdl/aluAddSub.sv */
// Combinational add/sub of dstD and srcA; byte size leaves the dstD upper byte in sum
`timescale 1ns/1ns
module aluAddSub (
	input logic [aluPkg::dataWidth-1:0] srcA,
	input logic [aluPkg::dataWidth-1:0] dstD,
	input logic carryIn,
	input logic subtract, // dstD - srcA - carryIn
	input logic isByte,
	output logic [aluPkg::dataWidth-1:0] sum,
	output logic carryOut,
	output logic overflow,
	output logic halfCarry // Out of bit 3, for BCD
);
	logic [aluPkg::dataWidth:0] wordRaw; // Extra bit is carry or borrow
	logic [aluPkg::byteWidth:0] byteRaw;
	logic srcMsb, dstMsb, resMsb;

	always_comb begin
		if (subtract) begin
			wordRaw = {1'b0, dstD} - {1'b0, srcA} - {{aluPkg::dataWidth{1'b0}}, carryIn};
			byteRaw = {1'b0, dstD[7:0]} - {1'b0, srcA[7:0]} - {{aluPkg::byteWidth{1'b0}}, carryIn};
		end else begin
			wordRaw = {1'b0, dstD} + {1'b0, srcA} + {{aluPkg::dataWidth{1'b0}}, carryIn};
			byteRaw = {1'b0, dstD[7:0]} + {1'b0, srcA[7:0]} + {{aluPkg::byteWidth{1'b0}}, carryIn};
		end
		sum = isByte ? {dstD[15:8], byteRaw[7:0]} : wordRaw[15:0];
		carryOut = isByte ? byteRaw[8] : wordRaw[16];
		// Signed overflow from operand and result signs
		dstMsb = isByte ? dstD[7] : dstD[15];
		srcMsb = (isByte ? srcA[7] : srcA[15]) ^ subtract; // Source sign flips on subtract
		resMsb = isByte ? byteRaw[7] : wordRaw[15];
		overflow = (srcMsb & dstMsb & ~resMsb) | (~srcMsb & ~dstMsb & resMsb);
		halfCarry = srcA[4] ^ dstD[4] ^ byteRaw[4]; // Carry into bit 4
	end

endmodule

/* hdl/aluBcdCorrect.sv */
// Decimal adjust of a binary byte sum or difference; inputs must be valid packed BCD
`timescale 1ns/1ns
module aluBcdCorrect (
	input logic [aluPkg::byteWidth-1:0] binSum,
	input logic halfCarry, // Carry or borrow out of bit 3
	input logic binCarry, // Carry or borrow out of bit 7
	input logic isAdd, // ABCD when set, else SBCD
	output logic [aluPkg::byteWidth-1:0] bcdResult,
	output logic decCarry
);
	logic lowAdj;
	logic highAdj;
	logic [aluPkg::byteWidth:0] lowFixed; // Bit 8 catches carry from low fix

	always_comb begin
		// Low nibble first, its carry can push the high nibble past 9
		lowAdj = halfCarry | (isAdd & (binSum[3:0] > 4'd9));
		if (isAdd)
			lowFixed = {1'b0, binSum} + (lowAdj ? 9'h006 : 9'h000);
		else
			lowFixed = {1'b0, binSum} - (lowAdj ? 9'h006 : 9'h000);

		// Subtract only corrects on a real borrow
		highAdj = binCarry | (isAdd & (lowFixed[8] | (lowFixed[7:4] > 4'd9)));
		if (isAdd)
			bcdResult = lowFixed[7:0] + (highAdj ? 8'h60 : 8'h00);
		else
			bcdResult = lowFixed[7:0] - (highAdj ? 8'h60 : 8'h00);

		decCarry = highAdj; // Decimal carry out or borrow
	end

endmodule

/* hdl/aluPkg.sv */
// Shared ALU definitions; word is 16 bits, the CCR holds X N Z V C only, no supervisor byte
package aluPkg;

	localparam int dataWidth = 16;
	localparam int byteWidth = 8; // Low byte, used by byte ops and BCD
	localparam int ccrWidth = 5;

	localparam int queueDepth = 4; // Also the requester's starting credits
	localparam int queuePtrWidth = $clog2(queueDepth);
	localparam int queueCntWidth = queuePtrWidth + 1; // Must hold a full queue

	localparam int rspCredits = 2; // Response credits held after reset
	localparam int creditWidth = $clog2(rspCredits + 1);

	// CCR bit positions, same order as the 68000 low CCR byte
	localparam int flagC = 0;
	localparam int flagV = 1;
	localparam int flagZ = 2;
	localparam int flagN = 3;
	localparam int flagX = 4;

	typedef enum logic [4:0] {
		opAnd,
		opOr,
		opEor,
		opAdd,
		opSub,
		opAddx, // Carry in from X
		opSubx,
		opAsl, // One-bit shifts
		opAsr,
		opLsl,
		opLsr,
		opRol, // One-bit rotates
		opRor,
		opRoxl, // Rotate through X
		opRoxr,
		opAbcd,
		opSbcd,
		opSetCcr = 5'h1f // Spare code, direct CCR load
	} aluOpT;

	typedef logic [ccrWidth-1:0] ccrT;

	// 38 bits
	typedef struct packed {
		aluOpT op;
		logic isByte;
		logic [dataWidth-1:0] srcA;
		logic [dataWidth-1:0] dstD;
	} aluReqT;

	// 21 bits
	typedef struct packed {
		logic [dataWidth-1:0] result;
		ccrT ccr; // CCR after this op
	} aluRspT;

endpackage

/* hdl/aluSequencer.sv */
// Queue, credits, two pipe stages and CCR; requester must honor reqCredit, no overflow check on the queue
`timescale 1ns/1ns
module aluSequencer (
	input logic clk,
	input logic rstN,
	input logic reqValid,
	input aluPkg::aluReqT req,
	input logic rspCredit,
	input logic [aluPkg::dataWidth-1:0] sum,
	input logic carryOut,
	input logic overflow,
	input logic [aluPkg::dataWidth-1:0] shifted,
	input logic outBit,
	input logic msbChanged,
	input logic [aluPkg::byteWidth-1:0] bcdResult,
	input logic decCarry,
	output logic reqCredit,
	output logic rspValid,
	output aluPkg::aluRspT rsp,
	output aluPkg::aluReqT stageReq, // Stage 1 to the datapath
	output logic carryIn,
	output logic subtract,
	output logic xFlag,
	output logic bcdIsAdd
);
	aluPkg::aluReqT queueMem [aluPkg::queueDepth];
	logic [aluPkg::queuePtrWidth-1:0] wrPtr, rdPtr;
	logic [aluPkg::queueCntWidth-1:0] fill;
	logic [aluPkg::creditWidth-1:0] rspCredCnt; // Free response slots incl. in flight
	logic pop;
	aluPkg::aluReqT stage1Req;
	logic stage1Valid;
	aluPkg::ccrT ccrReg, nextCcr;
	logic [aluPkg::dataWidth-1:0] result, logicVal;
	logic resN, resZ;

	// Credit reserved at pop so the pipe never stalls
	assign pop = (fill != '0) && (rspCredCnt != '0);

	always_ff @(posedge clk) begin
		if (reqValid)
			queueMem[wrPtr] <= req;
		if (pop)
			stage1Req <= queueMem[rdPtr];
		if (stage1Valid)
			rsp <= {result, nextCcr}; // Stage 2
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			fill <= '0;
			rspCredCnt <= aluPkg::creditWidth'(aluPkg::rspCredits);
			reqCredit <= 1'b0;
			stage1Valid <= 1'b0;
			rspValid <= 1'b0;
			ccrReg <= '0;
		end else begin
			if (reqValid)
				wrPtr <= wrPtr + 1'b1;
			if (pop)
				rdPtr <= rdPtr + 1'b1;
			case ({reqValid, pop})
				2'b10: fill <= fill + 1'b1;
				2'b01: fill <= fill - 1'b1;
				default: ;
			endcase
			case ({rspCredit, pop})
				2'b10: rspCredCnt <= rspCredCnt + 1'b1;
				2'b01: rspCredCnt <= rspCredCnt - 1'b1;
				default: ;
			endcase
			reqCredit <= pop; // One pulse per entry leaving
			stage1Valid <= pop;
			rspValid <= stage1Valid;
			if (stage1Valid)
				ccrReg <= nextCcr; // Next op sees this CCR
		end
	end

	// Datapath controls
	always_comb begin
		stageReq = stage1Req;
		if (stage1Req.op inside {aluPkg::opAbcd, aluPkg::opSbcd})
			stageReq.isByte = 1'b1; // BCD is byte only
		xFlag = ccrReg[aluPkg::flagX];
		bcdIsAdd = (stage1Req.op == aluPkg::opAbcd);
		subtract = stage1Req.op inside {aluPkg::opSub, aluPkg::opSubx, aluPkg::opSbcd};
		if (stage1Req.op inside {aluPkg::opAddx, aluPkg::opSubx, aluPkg::opAbcd, aluPkg::opSbcd})
			carryIn = xFlag;
		else
			carryIn = 1'b0;
	end

	// Result select
	always_comb begin
		case (stageReq.op)
			aluPkg::opOr: logicVal = stageReq.srcA | stageReq.dstD;
			aluPkg::opEor: logicVal = stageReq.srcA ^ stageReq.dstD;
			default: logicVal = stageReq.srcA & stageReq.dstD;
		endcase
		case (stageReq.op)
			aluPkg::opAnd, aluPkg::opOr, aluPkg::opEor:
				result = stageReq.isByte ? {stageReq.dstD[15:8], logicVal[7:0]} : logicVal;
			aluPkg::opAdd, aluPkg::opSub, aluPkg::opAddx, aluPkg::opSubx:
				result = sum;
			aluPkg::opAsl, aluPkg::opAsr, aluPkg::opLsl, aluPkg::opLsr,
			aluPkg::opRol, aluPkg::opRor, aluPkg::opRoxl, aluPkg::opRoxr:
				result = shifted;
			aluPkg::opAbcd, aluPkg::opSbcd:
				result = {stageReq.dstD[15:8], bcdResult};
			default: result = stageReq.dstD; // SETCCR passes dstD
		endcase
	end

	// Flag rules against the live CCR
	always_comb begin
		resN = stageReq.isByte ? result[7] : result[15];
		resZ = stageReq.isByte ? (result[7:0] == '0) : (result == '0);
		nextCcr = ccrReg;
		nextCcr[aluPkg::flagN] = resN;
		nextCcr[aluPkg::flagZ] = resZ;
		case (stageReq.op)
			aluPkg::opAnd, aluPkg::opOr, aluPkg::opEor: begin
				nextCcr[aluPkg::flagV] = 1'b0;
				nextCcr[aluPkg::flagC] = 1'b0;
			end
			aluPkg::opAdd, aluPkg::opSub, aluPkg::opAddx, aluPkg::opSubx: begin
				nextCcr[aluPkg::flagC] = carryOut;
				nextCcr[aluPkg::flagX] = carryOut;
				nextCcr[aluPkg::flagV] = overflow;
				if (stageReq.op inside {aluPkg::opAddx, aluPkg::opSubx})
					nextCcr[aluPkg::flagZ] = ccrReg[aluPkg::flagZ] & resZ; // Sticky over a chain
			end
			aluPkg::opAsl, aluPkg::opAsr, aluPkg::opLsl, aluPkg::opLsr,
			aluPkg::opRoxl, aluPkg::opRoxr: begin
				nextCcr[aluPkg::flagC] = outBit;
				nextCcr[aluPkg::flagX] = outBit;
				nextCcr[aluPkg::flagV] = (stageReq.op == aluPkg::opAsl) ? msbChanged : 1'b0;
			end
			aluPkg::opRol, aluPkg::opRor: begin
				nextCcr[aluPkg::flagC] = outBit; // X untouched
				nextCcr[aluPkg::flagV] = 1'b0;
			end
			aluPkg::opAbcd, aluPkg::opSbcd: begin
				nextCcr[aluPkg::flagC] = decCarry;
				nextCcr[aluPkg::flagX] = decCarry;
				nextCcr[aluPkg::flagV] = 1'b0;
				nextCcr[aluPkg::flagZ] = ccrReg[aluPkg::flagZ] & resZ;
			end
			aluPkg::opSetCcr: nextCcr = stageReq.dstD[aluPkg::ccrWidth-1:0];
			default: nextCcr = ccrReg; // Unused codes leave the CCR alone
		endcase
	end

endmodule

/* hdl/aluShifter.sv */
// One-bit shift or rotate of dstD; byte size keeps the upper byte, non-shift ops give don't-care output
`timescale 1ns/1ns
module aluShifter (
	input logic [aluPkg::dataWidth-1:0] dstD,
	input aluPkg::aluOpT op,
	input logic isByte,
	input logic xIn, // X flag for ROXL/ROXR
	output logic [aluPkg::dataWidth-1:0] shifted,
	output logic outBit,
	output logic msbChanged // Sign flipped, ASL overflow
);
	logic goRight;
	logic fillBit;
	logic oldMsb;
	logic newMsb;

	always_comb begin
		oldMsb = isByte ? dstD[7] : dstD[15];
		goRight = op inside {aluPkg::opAsr, aluPkg::opLsr, aluPkg::opRor, aluPkg::opRoxr};

		case (op)
			aluPkg::opAsr: fillBit = oldMsb; // Sign kept
			aluPkg::opRol: fillBit = oldMsb;
			aluPkg::opRor: fillBit = dstD[0];
			aluPkg::opRoxl,
			aluPkg::opRoxr: fillBit = xIn;
			default: fillBit = 1'b0; // ASL, LSL, LSR
		endcase

		if (goRight) begin
			if (isByte)
				shifted = {dstD[15:8], fillBit, dstD[7:1]};
			else
				shifted = {fillBit, dstD[15:1]};
			outBit = dstD[0];
		end else begin
			if (isByte)
				shifted = {dstD[15:8], dstD[6:0], fillBit};
			else
				shifted = {dstD[14:0], fillBit};
			outBit = oldMsb;
		end

		newMsb = isByte ? shifted[7] : shifted[15];
		msbChanged = oldMsb ^ newMsb;
	end

endmodule

/* hdl/aluTop.sv */
// ALU top; requester starts with queueDepth credits, consumer returns rspCredit pulses
`timescale 1ns/1ns
module aluTop (
	input logic clk,
	input logic rstN,
	input logic reqValid,
	input aluPkg::aluReqT req,
	output logic reqCredit,
	output logic rspValid,
	output aluPkg::aluRspT rsp,
	input logic rspCredit
);
	aluPkg::aluReqT stageReq;
	logic [aluPkg::dataWidth-1:0] sum;
	logic [aluPkg::dataWidth-1:0] shifted;
	logic [aluPkg::byteWidth-1:0] bcdResult;
	logic carryOut, overflow, halfCarry;
	logic outBit, msbChanged;
	logic decCarry;
	logic carryIn, subtract, xFlag, bcdIsAdd; // Sequencer controls

	aluSequencer seq0 (
		.clk, .rstN,
		.reqValid, .req, .rspCredit,
		.sum, .carryOut, .overflow,
		.shifted, .outBit, .msbChanged,
		.bcdResult, .decCarry,
		.reqCredit, .rspValid, .rsp,
		.stageReq, .carryIn, .subtract, .xFlag, .bcdIsAdd
	);

	aluAddSub addSub0 (
		.srcA(stageReq.srcA), .dstD(stageReq.dstD),
		.carryIn, .subtract, .isByte(stageReq.isByte),
		.sum, .carryOut, .overflow, .halfCarry
	);

	aluShifter shifter0 (
		.dstD(stageReq.dstD), .op(stageReq.op), .isByte(stageReq.isByte),
		.xIn(xFlag), .shifted, .outBit, .msbChanged
	);

	// Corrects the adder's low byte
	aluBcdCorrect bcd0 (
		.binSum(sum[aluPkg::byteWidth-1:0]), .halfCarry, .binCarry(carryOut),
		.isAdd(bcdIsAdd), .bcdResult, .decCarry
	);

endmodule

/* src.f */
hdl/aluPkg.sv
hdl/aluAddSub.sv
hdl/aluShifter.sv
hdl/aluBcdCorrect.sv
hdl/aluSequencer.sv
hdl/aluTop.sv
verification/aluTb.sv

/* verification/aluTb.sv */
// Run from the project root, vectors come from verification/aluVectors.txt in order, 64 at most
`timescale 1ns/1ns
module aluTb;
	localparam int maxVecs = 64;
	localparam int fieldsPerVec = 6; // op, size, srcA, dstD, result, ccr
	localparam logic [15:0] endMarker = 16'h00ff;

	logic clk;
	logic rstN;
	logic reqValid;
	aluPkg::aluReqT req;
	logic reqCredit;
	logic rspValid;
	aluPkg::aluRspT rsp;
	logic rspCredit;

	logic [15:0] vecMem [maxVecs*fieldsPerVec];
	int numVecs = 0;
	int sentCnt = 0; // Requests driven
	int creditBackCnt = 0; // reqCredit pulses seen
	int rspCnt = 0; // Responses checked
	int creditGivenCnt = 0; // rspCredit pulses driven
	int failCnt = 0; // Failed checks of any kind
	int testFailCnt = 0;
	int cycleCnt = 0;
	int cycleLimit = 100;

	aluTop dut0 (.clk, .rstN, .reqValid, .req, .reqCredit, .rspValid, .rsp, .rspCredit);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk; // 40 ns period
	end

	function automatic aluPkg::aluReqT vecReq(input int idx);
		aluPkg::aluReqT r;
		r.op = aluPkg::aluOpT'(vecMem[idx*fieldsPerVec][4:0]);
		r.isByte = vecMem[idx*fieldsPerVec+1][0];
		r.srcA = vecMem[idx*fieldsPerVec+2];
		r.dstD = vecMem[idx*fieldsPerVec+3];
		return r;
	endfunction

	// Index, op and size, e.g. v4_opAdd_w
	function automatic string testName(input int idx);
		aluPkg::aluReqT r;
		aluPkg::aluOpT op;
		r = vecReq(idx);
		op = r.op;
		return $sformatf("v%0d_%s_%s", idx, op.name(), r.isByte ? "b" : "w");
	endfunction

	task automatic checkData(input string name, input logic [aluPkg::dataWidth-1:0] expected,
			input logic [aluPkg::dataWidth-1:0] actual, inout bit ok);
		if (actual !== expected) begin
			$display("[ERROR] %s result expected %h actual %h", name, expected, actual);
			failCnt++;
			ok = 1'b0;
		end
	endtask

	task automatic checkCcr(input string name, input aluPkg::ccrT expected,
			input aluPkg::ccrT actual, inout bit ok);
		if (actual !== expected) begin
			$display("[ERROR] %s ccr XNZVC expected %b actual %b", name, expected, actual);
			failCnt++;
			ok = 1'b0;
		end
	endtask

	// Spends one credit per request, waits while none are held
	task automatic sendRequests();
		int held;
		while (sentCnt < numVecs) begin
			@(posedge clk);
			#5;
			held = aluPkg::queueDepth - sentCnt + creditBackCnt;
			if (held > 0) begin
				reqValid = 1'b1;
				req = vecReq(sentCnt);
				sentCnt++;
			end else begin
				reqValid = 1'b0;
			end
		end
		@(posedge clk);
		#5;
		reqValid = 1'b0;
	endtask

	// One credit back per response, 0 to 6 cycles later
	task automatic returnCredits();
		int waitLeft;
		waitLeft = $urandom % 7;
		forever begin
			@(posedge clk);
			#5;
			rspCredit = 1'b0;
			if (rspCnt > creditGivenCnt) begin
				if (waitLeft == 0) begin
					rspCredit = 1'b1;
					creditGivenCnt++;
					waitLeft = $urandom % 7;
				end else begin
					waitLeft--;
				end
			end
		end
	endtask

	// Outputs sampled mid cycle
	always @(negedge clk) begin
		bit ok;
		string name;
		if (rstN) begin
			if (reqCredit) begin
				creditBackCnt++;
				if (creditBackCnt > sentCnt) begin
					$display("reqCredit pulsed more often than requests were sent");
					failCnt++;
				end
			end
			if (rspValid) begin
				if (aluPkg::rspCredits + creditGivenCnt - rspCnt <= 0) begin
					$display("rspValid rose while the DUT held no response credits");
					failCnt++;
				end
				if (rspCnt >= numVecs) begin
					$display("Response arrived with no request left to match it");
					failCnt++;
				end else begin
					ok = 1'b1;
					name = testName(rspCnt);
					checkData(name, vecMem[rspCnt*fieldsPerVec+4], rsp.result, ok);
					checkCcr(name, vecMem[rspCnt*fieldsPerVec+5][4:0], rsp.ccr, ok);
					if (!ok)
						testFailCnt++;
					$display("%s %s", name, ok ? "ok" : "FAILED");
				end
				rspCnt++; // In order, so this indexes the next vector
			end
		end
	end

	always @(posedge clk) begin
		cycleCnt++;
		if (cycleCnt >= cycleLimit) begin
			$display("Timeout after %0d cycles with %0d of %0d responses", cycleCnt, rspCnt, numVecs);
			$display("Errors found");
			$finish;
		end
	end

	initial begin
		int i;
		bit foundEnd;
		void'($urandom(90694));
		rstN = 1'b0;
		reqValid = 1'b0;
		req = '0;
		rspCredit = 1'b0;
		$readmemh("verification/aluVectors.txt", vecMem);
		foundEnd = 1'b0;
		for (i = 0; i < maxVecs && !foundEnd; i++) begin
			if (vecMem[i*fieldsPerVec] == endMarker)
				foundEnd = 1'b1;
			else
				numVecs++;
		end
		cycleLimit = 20 * numVecs + 100; // Includes the reset cycles
		if (!foundEnd || numVecs == 0) begin
			$display("Vector file is missing, empty or has no end marker");
			$display("Errors found");
			$finish;
		end else begin
			repeat (8) @(posedge clk);
			#5;
			rstN = 1'b1;
			fork
				sendRequests();
				returnCredits();
			join_none
			wait (rspCnt == numVecs);
			repeat (2) @(negedge clk); // Catch stray extra responses
			if (creditBackCnt != sentCnt) begin
				$display("Saw %0d reqCredit pulses for %0d requests", creditBackCnt, sentCnt);
				failCnt++;
			end
			$display("Tests %0d, passed %0d, failed %0d, failed checks %0d",
				numVecs, numVecs - testFailCnt, testFailCnt, failCnt);
			if (failCnt == 0)
				$display("No errors");
			else
				$display("Errors found");
			$finish;
		end
	end

endmodule

/* verification/aluVectors.txt */
// op isByte srcA dstD result ccr, all hex, ccr bits are X N Z V C
// Each line sees the CCR left by the line before it, op ff ends the list
00 0 f0f0 0ff0 00f0 00 // AND word
01 1 0080 1200 1280 08 // OR byte, upper byte kept
02 0 a5a5 a5a5 0000 04 // EOR to zero
03 0 7fff 0001 8000 0a // ADD signed overflow
03 1 0001 34ff 3400 15 // ADD byte carry
04 0 0001 8000 7fff 02 // SUB signed overflow
04 1 0010 ab05 abf5 19 // SUB byte borrow
1f 0 0000 0014 0014 14 // SETCCR X and Z
05 0 0000 ffff 0000 15 // ADDX zero keeps Z
05 0 0001 0000 0002 00 // ADDX nonzero clears Z
05 0 0000 0000 0000 00 // Z stays clear
06 1 0001 5500 55ff 19 // SUBX byte borrow
06 1 0000 0001 0000 00 // SUBX uses X
07 0 0000 4000 8000 0a // ASL sign change
07 1 0000 12c0 1280 19
08 0 0000 8001 c000 19 // ASR keeps sign
09 1 0000 0080 0000 15
0a 0 0000 8000 4000 00
0e 0 0000 0001 0000 15 // ROXR with X clear
0b 0 0000 8000 0001 11 // ROL, X kept
0c 1 0000 3402 3401 10 // ROR byte, X kept
0d 1 0000 0040 0081 08 // ROXL pulls in X
0d 0 0000 8000 0000 15
0f 0 0045 0038 0084 08 // ABCD 38+45+1
0f 0 0099 1201 1200 11 // ABCD wraps, Z not set
10 0 0027 0042 0014 00 // SBCD 42-27-1
10 0 0001 ab00 ab99 19 // SBCD borrow
1f 0 0000 0010 0010 10 // SETCCR X only
05 0 1000 2000 3001 00 // ADDX sees loaded X
03 0 8000 8000 0000 17
02 1 00ff 5a0f 5af0 18
ff 0 0000 0000 0000 00
